//--- src/i2c_sys_pkg.sv
package i2c_sys_pkg;

    // bit timing.
    localparam int QUARTER_CYCLES = 4;                   // i2c_clk cycles per quarter bit.
    localparam int QCNT_W         = $clog2(QUARTER_CYCLES);

    // last count value inside one quarter.
    localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(QUARTER_CYCLES - 1);

    // read count per transaction, stored as count minus one.
    localparam int RD_CNT_W = 2;

    // receive FIFO.
    localparam int RX_DEPTH = 4;
    localparam int RX_PTR_W = 2;
    localparam int RX_CNT_W = RX_PTR_W + 1;              // holds 0 to RX_DEPTH.

    localparam logic [RX_CNT_W-1:0] RX_FULL_CNT = RX_CNT_W'(RX_DEPTH);

endpackage

//--- src/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // transaction opcodes.
    typedef enum logic [1:0] {
        OP_WRITE      = 2'd0,    // one byte out.
        OP_READ       = 2'd1,    // nbytes+1 bytes in.
        OP_WRITE_READ = 2'd2     // one byte out, repeated start, then read.
    } i2c_op_e;

    // sequencer states, one per bit type on the wire.
    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,
        ST_START     = 4'd1,
        ST_ADDR      = 4'd2,
        ST_ADDR_ACK  = 4'd3,
        ST_WDATA     = 4'd4,
        ST_WDATA_ACK = 4'd5,
        ST_RDATA     = 4'd6,
        ST_RDATA_ACK = 4'd7,
        ST_RSTART    = 4'd8,
        ST_STOP      = 4'd9
    } i2c_state_e;

    // command, sampled on start.
    typedef struct packed {
        i2c_op_e                            op;
        logic [6:0]                         addr;     // 7-bit slave address.
        logic [7:0]                         wdata;
        logic [i2c_sys_pkg::RD_CNT_W-1:0]   nbytes;   // read count minus one.
    } i2c_cmd_t;

    // status back to the host.
    typedef struct packed {
        logic busy;
        logic done;     // one cycle, as busy falls.
        logic nack;     // any ack slot sampled high.
    } i2c_status_t;

endpackage

//--- src/i2c_bit_timer.sv
`timescale 1ns/100ps

module i2c_bit_timer (
    input  logic i2c_clk,
    input  logic rst_n,
    input  logic run_i,
    output logic q0_o,
    output logic q1_o,
    output logic q2_o,
    output logic q3_o,
    output logic scl_pull_o
);

    logic [i2c_sys_pkg::QCNT_W-1:0] cnt_q;
    logic [1:0]                     quarter_q;
    logic                           first_bit_q;
    logic                           tick;

    assign tick = run_i && (cnt_q == '0);    // first cycle of a quarter.

    assign q0_o = tick && (quarter_q == 2'd0);
    assign q1_o = tick && (quarter_q == 2'd1);
    assign q2_o = tick && (quarter_q == 2'd2);
    assign q3_o = tick && (quarter_q == 2'd3);

    // scl low in the first half of a bit.
    // the first bit of a run is the start bit, so scl stays high through it.
    assign scl_pull_o = run_i && !first_bit_q && !quarter_q[1];

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q       <= '0;
            quarter_q   <= 2'd0;
            first_bit_q <= 1'b1;
        end else if (!run_i) begin
            cnt_q       <= '0;       // park on a clean bit boundary.
            quarter_q   <= 2'd0;
            first_bit_q <= 1'b1;
        end else begin
            if (cnt_q == i2c_sys_pkg::QCNT_LAST) begin
                cnt_q     <= '0;
                quarter_q <= quarter_q + 2'd1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (q3_o)
                first_bit_q <= 1'b0;
        end
    end

    // ticks never overlap.
    a_one_tick: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        $onehot0({q0_o, q1_o, q2_o, q3_o}));

endmodule

//--- src/i2c_master_fsm.sv
`timescale 1ns/100ps

module i2c_master_fsm (
    input  logic                     i2c_clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  i2c_bus_pkg::i2c_cmd_t    cmd_i,
    input  logic                     q0_i,
    input  logic                     q1_i,
    input  logic                     q2_i,
    input  logic                     q3_i,
    input  logic                     sda_i,
    output logic                     run_o,
    output logic                     sda_pull_o,
    output i2c_bus_pkg::i2c_status_t status_o,
    output logic                     rx_push_o,
    output logic [7:0]               rx_byte_o
);

    i2c_bus_pkg::i2c_state_e          state_q;
    i2c_bus_pkg::i2c_cmd_t            cmd_q;
    i2c_bus_pkg::i2c_status_t         status_q;
    logic [7:0]                       shreg_q;     // address/data out, read data in.
    logic [2:0]                       bit_cnt_q;
    logic [i2c_sys_pkg::RD_CNT_W-1:0] rd_cnt_q;    // read bytes left, minus one.
    logic                             rd_phase_q;  // past the repeated start.
    logic                             rd_bit;

    assign rd_bit    = (cmd_q.op == i2c_bus_pkg::OP_READ) || rd_phase_q;
    assign status_o  = status_q;
    assign rx_byte_o = shreg_q;

    // command latch.
    always_ff @(posedge i2c_clk) begin
        if (state_q == i2c_bus_pkg::ST_IDLE && start_i)
            cmd_q <= cmd_i;
    end

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= i2c_bus_pkg::ST_IDLE;
            status_q   <= '0;
            run_o      <= 1'b0;
            sda_pull_o <= 1'b0;
            rx_push_o  <= 1'b0;
            shreg_q    <= '0;
            bit_cnt_q  <= 3'd7;
            rd_cnt_q   <= '0;
            rd_phase_q <= 1'b0;
        end else begin
            status_q.done <= 1'b0;
            rx_push_o     <= 1'b0;

            case (state_q)
                i2c_bus_pkg::ST_IDLE: begin
                    if (start_i) begin
                        status_q.busy <= 1'b1;
                        status_q.nack <= 1'b0;
                        rd_phase_q    <= 1'b0;
                        bit_cnt_q     <= 3'd7;
                        run_o         <= 1'b1;
                        state_q       <= i2c_bus_pkg::ST_START;
                    end
                end

                i2c_bus_pkg::ST_START: begin
                    run_o <= 1'b1;                        // rearms the timer after rstart.
                    if (q1_i)
                        sda_pull_o <= 1'b1;               // sda falls, scl high.
                    if (q3_i) begin
                        shreg_q <= {cmd_q.addr, rd_bit};
                        state_q <= i2c_bus_pkg::ST_ADDR;
                    end
                end

                i2c_bus_pkg::ST_ADDR, i2c_bus_pkg::ST_WDATA: begin
                    if (q0_i) begin
                        sda_pull_o <= ~shreg_q[7];        // msb first.
                        shreg_q    <= {shreg_q[6:0], 1'b0};
                    end
                    if (q3_i) begin
                        bit_cnt_q <= bit_cnt_q - 3'd1;    // wraps to 7 for the next byte.
                        if (bit_cnt_q == 3'd0)
                            state_q <= (state_q == i2c_bus_pkg::ST_ADDR) ?
                                       i2c_bus_pkg::ST_ADDR_ACK : i2c_bus_pkg::ST_WDATA_ACK;
                    end
                end

                i2c_bus_pkg::ST_ADDR_ACK, i2c_bus_pkg::ST_WDATA_ACK: begin
                    if (q0_i)
                        sda_pull_o <= 1'b0;               // let the slave answer.
                    if (q2_i && sda_i)
                        status_q.nack <= 1'b1;
                    if (q3_i) begin
                        if (status_q.nack) begin
                            state_q <= i2c_bus_pkg::ST_STOP;
                        end else if (state_q == i2c_bus_pkg::ST_ADDR_ACK) begin
                            if (rd_bit) begin
                                rd_cnt_q <= cmd_q.nbytes;
                                state_q  <= i2c_bus_pkg::ST_RDATA;
                            end else begin
                                shreg_q <= cmd_q.wdata;
                                state_q <= i2c_bus_pkg::ST_WDATA;
                            end
                        end else if (cmd_q.op == i2c_bus_pkg::OP_WRITE_READ) begin
                            rd_phase_q <= 1'b1;
                            state_q    <= i2c_bus_pkg::ST_RSTART;
                        end else begin
                            state_q <= i2c_bus_pkg::ST_STOP;
                        end
                    end
                end

                i2c_bus_pkg::ST_RDATA: begin
                    if (q0_i)
                        sda_pull_o <= 1'b0;
                    if (q2_i)
                        shreg_q <= {shreg_q[6:0], sda_i};
                    if (q3_i) begin
                        bit_cnt_q <= bit_cnt_q - 3'd1;
                        if (bit_cnt_q == 3'd0) begin
                            rx_push_o <= 1'b1;            // full byte in shreg_q.
                            state_q   <= i2c_bus_pkg::ST_RDATA_ACK;
                        end
                    end
                end

                i2c_bus_pkg::ST_RDATA_ACK: begin
                    if (q0_i)
                        sda_pull_o <= (rd_cnt_q != '0);   // nack on the last byte.
                    if (q3_i) begin
                        if (rd_cnt_q == '0) begin
                            state_q <= i2c_bus_pkg::ST_STOP;
                        end else begin
                            rd_cnt_q <= rd_cnt_q - 1'b1;
                            state_q  <= i2c_bus_pkg::ST_RDATA;
                        end
                    end
                end

                // released sda bit, then a fresh start bit with scl held high.
                i2c_bus_pkg::ST_RSTART: begin
                    if (q0_i)
                        sda_pull_o <= 1'b0;
                    if (q3_i) begin
                        run_o   <= 1'b0;
                        state_q <= i2c_bus_pkg::ST_START;
                    end
                end

                i2c_bus_pkg::ST_STOP: begin
                    if (q0_i)
                        sda_pull_o <= 1'b1;
                    if (q3_i) begin
                        sda_pull_o    <= 1'b0;            // sda rises, scl high.
                        run_o         <= 1'b0;
                        status_q.busy <= 1'b0;
                        status_q.done <= 1'b1;
                        state_q       <= i2c_bus_pkg::ST_IDLE;
                    end
                end

                default: state_q <= i2c_bus_pkg::ST_IDLE;
            endcase
        end
    end

    // sda moves only in the scl-low quarter, apart from start and stop framing.
    a_sda_stable: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        $changed(sda_pull_o) |-> $past(q0_i) ||
            ($past(state_q) inside {i2c_bus_pkg::ST_START, i2c_bus_pkg::ST_RSTART,
                                    i2c_bus_pkg::ST_STOP}));

    // done only on the way out of stop.
    a_done_idle: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        status_q.done |-> state_q == i2c_bus_pkg::ST_IDLE &&
                          $past(state_q) == i2c_bus_pkg::ST_STOP);

endmodule

//--- src/i2c_rx_fifo.sv
`timescale 1ns/100ps

module i2c_rx_fifo (
    input  logic       i2c_clk,
    input  logic       rst_n,
    input  logic       push_i,
    input  logic [7:0] data_i,
    input  logic       pop_i,
    output logic [7:0] data_o,
    output logic       empty_o,
    output logic       full_o
);

    logic [7:0]                       mem_q [i2c_sys_pkg::RX_DEPTH];
    logic [i2c_sys_pkg::RX_PTR_W-1:0] wr_ptr_q;
    logic [i2c_sys_pkg::RX_PTR_W-1:0] rd_ptr_q;
    logic [i2c_sys_pkg::RX_CNT_W-1:0] cnt_q;
    logic                             do_push;
    logic                             do_pop;

    assign empty_o = (cnt_q == '0);
    assign full_o  = (cnt_q == i2c_sys_pkg::RX_FULL_CNT);
    assign do_push = push_i && !full_o;    // dropped when full.
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem_q[rd_ptr_q];      // head byte.

    always_ff @(posedge i2c_clk) begin
        if (do_push)
            mem_q[wr_ptr_q] <= data_i;
    end

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;   // pointers wrap at depth.
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        push_i |-> !full_o) else $error("rx fifo push while full");

    a_no_underflow: assert property (@(posedge i2c_clk) disable iff (!rst_n)
        pop_i |-> !empty_o) else $error("rx fifo pop while empty");

endmodule

//--- src/i2c_master_top.sv
`timescale 1ns/100ps

module i2c_master_top (
    input  logic                     i2c_clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  i2c_bus_pkg::i2c_cmd_t    cmd_i,
    output i2c_bus_pkg::i2c_status_t status_o,
    input  logic                     rx_pop_i,
    output logic [7:0]               rx_data_o,
    output logic                     rx_empty_o,
    output logic                     scl_pull_o,
    output logic                     sda_pull_o,
    input  logic                     sda_i
);

    logic       run;
    logic       q0;
    logic       q1;
    logic       q2;
    logic       q3;
    logic       rx_push;
    logic [7:0] rx_byte;

    i2c_bit_timer u_timer (
        .i2c_clk    (i2c_clk),
        .rst_n      (rst_n),
        .run_i      (run),
        .q0_o       (q0),
        .q1_o       (q1),
        .q2_o       (q2),
        .q3_o       (q3),
        .scl_pull_o (scl_pull_o)
    );

    i2c_master_fsm u_fsm (
        .i2c_clk    (i2c_clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .cmd_i      (cmd_i),
        .q0_i       (q0),
        .q1_i       (q1),
        .q2_i       (q2),
        .q3_i       (q3),
        .sda_i      (sda_i),
        .run_o      (run),
        .sda_pull_o (sda_pull_o),
        .status_o   (status_o),
        .rx_push_o  (rx_push),
        .rx_byte_o  (rx_byte)
    );

    // full is only watched by the fifo itself.
    i2c_rx_fifo u_rx_fifo (
        .i2c_clk (i2c_clk),
        .rst_n   (rst_n),
        .push_i  (rx_push),
        .data_i  (rx_byte),
        .pop_i   (rx_pop_i),
        .data_o  (rx_data_o),
        .empty_o (rx_empty_o),
        .full_o  ()
    );

endmodule

//--- test/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h5A
) (
    input  logic       scl_i,
    input  logic       sda_i,
    output logic       sda_pull_o,
    output logic [7:0] reg_o,
    output logic       write_seen_o
);

    typedef enum logic [2:0] {
        SL_IDLE, SL_ADDR, SL_ADDR_ACK, SL_WRITE, SL_WRITE_ACK, SL_READ, SL_READ_ACK
    } slave_state_e;

    slave_state_e state      = SL_IDLE;
    logic [7:0]   shreg      = 8'h00;
    logic [7:0]   tx_byte    = 8'h00;
    logic         rw         = 1'b0;
    logic         master_ack = 1'b0;
    logic         scl_prev   = 1'b1;
    logic         sda_prev   = 1'b1;
    int           bit_cnt    = 0;
    int           rd_idx     = 0;

    initial begin
        sda_pull_o   = 1'b0;
        reg_o        = 8'h00;   // register value out of reset.
        write_seen_o = 1'b0;
    end

    // k-th byte of a read is register plus k.
    task load_read_byte();
        tx_byte    = reg_o + 8'(rd_idx);
        sda_pull_o = ~tx_byte[7];
        bit_cnt    = 1;
    endtask

    task sample_bit();
        case (state)
            SL_ADDR, SL_WRITE: begin
                shreg   = {shreg[6:0], (sda_i === 1'b1)};
                bit_cnt = bit_cnt + 1;
            end
            SL_READ_ACK: master_ack = (sda_i === 1'b0);
            default: ;
        endcase
    endtask

    // everything the slave drives changes right after scl falls.
    task drive_bit();
        case (state)
            SL_ADDR: begin
                if (bit_cnt == 8) begin
                    if (shreg[7:1] == DEV_ADDR) begin
                        rw         = shreg[0];
                        sda_pull_o = 1'b1;
                        state      = SL_ADDR_ACK;
                    end else begin
                        state = SL_IDLE;       // not ours, wait for the next start.
                    end
                end
            end
            SL_ADDR_ACK: begin
                sda_pull_o = 1'b0;
                bit_cnt    = 0;
                if (rw) begin
                    rd_idx = 0;
                    load_read_byte();
                    state = SL_READ;
                end else begin
                    state = SL_WRITE;
                end
            end
            SL_WRITE: begin
                if (bit_cnt == 8) begin
                    reg_o        = shreg;
                    write_seen_o = 1'b1;
                    sda_pull_o   = 1'b1;
                    state        = SL_WRITE_ACK;
                end
            end
            SL_WRITE_ACK: begin
                sda_pull_o = 1'b0;
                state      = SL_IDLE;          // single-byte writes only.
            end
            SL_READ: begin
                if (bit_cnt == 8) begin
                    sda_pull_o = 1'b0;         // master owns the ack slot.
                    state      = SL_READ_ACK;
                end else begin
                    sda_pull_o = ~tx_byte[7 - bit_cnt];
                    bit_cnt    = bit_cnt + 1;
                end
            end
            SL_READ_ACK: begin
                if (master_ack) begin
                    rd_idx = rd_idx + 1;
                    load_read_byte();
                    state = SL_READ;
                end else begin
                    state = SL_IDLE;
                end
            end
            default: ;
        endcase
    endtask

    always @(scl_i or sda_i) begin
        if (scl_i === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda_i === 1'b0) begin
            state      = SL_ADDR;              // start or repeated start.
            bit_cnt    = 0;
            sda_pull_o = 1'b0;
        end else if (scl_i === 1'b1 && scl_prev === 1'b1 &&
                     sda_prev === 1'b0 && sda_i === 1'b1) begin
            state      = SL_IDLE;              // stop.
            sda_pull_o = 1'b0;
        end else if (scl_prev === 1'b0 && scl_i === 1'b1) begin
            sample_bit();
        end else if (scl_prev === 1'b1 && scl_i === 1'b0) begin
            drive_bit();
        end
        scl_prev = scl_i;
        sda_prev = sda_i;
    end

endmodule

//--- test/i2c_master_tb.sv
`timescale 1ns/100ps

module i2c_master_tb;

    localparam logic [6:0] SLAVE_ADDR = 7'h5A;
    localparam int         BIT_CYCLES = 4 * i2c_sys_pkg::QUARTER_CYCLES;
    // longest command is a write-read of a full fifo with start, rstart and stop bits.
    localparam int MAX_TXN_BITS   = 1 + 9 + 9 + 1 + 1 + 9 + 9 * i2c_sys_pkg::RX_DEPTH + 1;
    localparam int NUM_ROWS       = 5;
    // one slot per row, one for the quiet window and one for reset.
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 2) * MAX_TXN_BITS * BIT_CYCLES;

    typedef struct packed {
        i2c_bus_pkg::i2c_cmd_t cmd;
        logic                  mid_start;   // second start while busy.
        logic                  exp_nack;
        logic [2:0]            exp_reads;
    } row_t;

    logic                     i2c_clk = 1'b0;
    logic                     rst_n;
    logic                     start;
    i2c_bus_pkg::i2c_cmd_t    cmd;
    i2c_bus_pkg::i2c_status_t status;
    logic                     rx_pop;
    logic [7:0]               rx_data;
    logic                     rx_empty;
    logic                     scl_pull;
    logic                     sda_pull;
    logic                     slave_sda_pull;
    logic                     scl_line;
    logic                     sda_line;
    logic [7:0]               slave_reg;
    logic                     write_seen;
    row_t                     rows [NUM_ROWS];
    string                    row_name [NUM_ROWS];
    logic [7:0]               exp_reg;
    int                       errors = 0;
    int                       checks = 0;
    int                       cycles = 0;

    // open drain, low when anyone pulls.
    assign scl_line = ~scl_pull;
    assign sda_line = ~(sda_pull | slave_sda_pull);

    i2c_master_top UUT (
        .i2c_clk (i2c_clk), .rst_n (rst_n), .start_i (start), .cmd_i (cmd),
        .status_o (status), .rx_pop_i (rx_pop), .rx_data_o (rx_data),
        .rx_empty_o (rx_empty), .scl_pull_o (scl_pull), .sda_pull_o (sda_pull),
        .sda_i (sda_line)
    );

    i2c_slave_model #(.DEV_ADDR (SLAVE_ADDR)) u_slave (
        .scl_i (scl_line), .sda_i (sda_line), .sda_pull_o (slave_sda_pull),
        .reg_o (slave_reg), .write_seen_o (write_seen)
    );

    always #4 i2c_clk = ~i2c_clk;

    always @(posedge i2c_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // expected values follow the slave rules: nack off-address, k-th read is reg + k.
    function automatic row_t make_row(input i2c_bus_pkg::i2c_op_e op, input logic [6:0] addr,
                                      input int nreads, input logic mid);
        row_t r;
        r.cmd.op     = op;
        r.cmd.addr   = addr;
        r.cmd.wdata  = 8'($urandom);
        r.cmd.nbytes = 2'(nreads - 1);
        r.mid_start  = mid;
        r.exp_nack   = (addr != SLAVE_ADDR);
        r.exp_reads  = (op == i2c_bus_pkg::OP_WRITE || r.exp_nack) ? 3'd0 : 3'(nreads);
        return r;
    endfunction

    task automatic issue_cmd(input i2c_bus_pkg::i2c_cmd_t c);
        @(posedge i2c_clk);
        cmd   <= c;
        start <= 1'b1;
        @(posedge i2c_clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_done();
        do @(negedge i2c_clk); while (status.done !== 1'b1);
    endtask

    task automatic drain_fifo(input int n, input logic [7:0] first);
        for (int k = 0; k < n; k++) begin
            @(negedge i2c_clk);
            check_value("rx_empty_o", rx_empty, 0);
            check_value("rx_data_o", rx_data, 8'(first + 8'(k)));
            @(posedge i2c_clk);
            rx_pop <= 1'b1;
            @(posedge i2c_clk);
            rx_pop <= 1'b0;
        end
        @(negedge i2c_clk);
        check_value("rx_empty_o", rx_empty, 1);
    endtask

    initial begin
        int                    err_before;
        int                    late;
        i2c_bus_pkg::i2c_cmd_t second_cmd;

        void'($urandom(32'hf35e9361));
        rst_n   = 1'b0;
        start   = 1'b0;
        cmd     = '0;
        rx_pop  = 1'b0;
        exp_reg = 8'h00;                           // slave register out of reset.

        rows[0] = make_row(i2c_bus_pkg::OP_WRITE, SLAVE_ADDR, 1, 1'b0);
        rows[1] = make_row(i2c_bus_pkg::OP_WRITE, 7'h5B, 1, 1'b0);
        rows[2] = make_row(i2c_bus_pkg::OP_READ, SLAVE_ADDR, 3, 1'b0);
        rows[3] = make_row(i2c_bus_pkg::OP_WRITE_READ, SLAVE_ADDR, 2, 1'b0);
        rows[4] = make_row(i2c_bus_pkg::OP_WRITE, SLAVE_ADDR, 1, 1'b1);
        row_name = '{"write", "wrong address", "read 3", "write then read", "start while busy"};

        repeat (5) @(posedge i2c_clk);
        rst_n <= 1'b1;
        @(negedge i2c_clk);
        check_value("status_o.busy", status.busy, 0);
        check_value("status_o.done", status.done, 0);
        check_value("status_o.nack", status.nack, 0);
        check_value("scl_pull_o", scl_pull, 0);
        check_value("sda_pull_o", sda_pull, 0);
        check_value("rx_empty_o", rx_empty, 1);
        check_value("write_seen_o", write_seen, 0);
        $display("test 0 reset: %s", (errors == 0) ? "ok" : "FAILED");

        for (int i = 0; i < NUM_ROWS; i++) begin
            err_before = errors;
            issue_cmd(rows[i].cmd);
            if (rows[i].mid_start) begin
                second_cmd       = rows[i].cmd;
                second_cmd.wdata = ~rows[i].cmd.wdata;
                repeat (3 * BIT_CYCLES) @(posedge i2c_clk);
                issue_cmd(second_cmd);
            end
            wait_for_done();
            check_value("status_o.busy", status.busy, 0);
            check_value("status_o.nack", status.nack, rows[i].exp_nack);
            if (!rows[i].exp_nack && rows[i].cmd.op != i2c_bus_pkg::OP_READ) begin
                exp_reg = rows[i].cmd.wdata;
                check_value("write_seen_o", write_seen, 1);
            end
            check_value("slave reg_o", slave_reg, exp_reg);
            drain_fifo(rows[i].exp_reads, exp_reg);
            if (rows[i].mid_start) begin
                late = 0;
                repeat (MAX_TXN_BITS * BIT_CYCLES) begin
                    @(negedge i2c_clk);
                    if (status.done || status.busy)
                        late++;
                end
                assert (late == 0) else begin
                    $display("Start pulsed while busy was not ignored, bus active again");
                    errors++;
                end
            end
            $display("test %0d %s: %s", i + 1, row_name[i],
                     (errors == err_before) ? "ok" : "FAILED");
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_ROWS + 1, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb.f
src/i2c_sys_pkg.sv
src/i2c_bus_pkg.sv
src/i2c_bit_timer.sv
src/i2c_master_fsm.sv
src/i2c_rx_fifo.sv
src/i2c_master_top.sv
test/i2c_slave_model.sv
test/i2c_master_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := i2c_master_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
